// ==== sources.f ====
src/execPkg.sv
src/regFile.sv
src/instrDecode.sv
src/aluCore.sv
src/execTop.sv
verification/execTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module execTb -o execSim
./obj_dir/execSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
   exit 0
fi
exit 1

// ==== verification/execInput.txt ====
// instr instrEn dataIn expResult expByteSel expCarry flag expBusAddr
// flag 0 none, 1 result, 2 idle slot, 3 result and bus address
20200064 1 00000000 00000064 0 0 1 00000000
2041FFFF 1 00000000 00000063 0 1 1 00000000
28600005 1 00000000 00000006 0 0 1 00000000
248100C8 1 00000000 00000064 0 1 1 00000000
24A30006 1 00000000 00000000 0 1 1 00000000
20040001 1 00000000 00000065 0 0 1 00000000
00C02000 1 00000000 00000064 0 0 1 00000000
A0E10F00 1 00000000 00000F64 0 0 1 00000000
A50700FF 1 00000000 00000064 0 0 1 00000000
89274000 1 00000000 00000F00 0 0 1 00000000
8D474000 1 00000000 00000F00 0 0 1 00000000
2161FFFF 1 00000000 00000063 0 1 1 00000000
91870021 1 00000000 800007B2 0 0 1 00000000
91AC0001 1 00000000 C00003D9 0 0 1 00000000
91CD0041 1 00000000 600001EC 0 1 1 00000000
91ED0060 1 00000000 FFFFFFD9 0 1 1 00000000
920C0061 1 00000000 000007B2 0 1 1 00000000
162D0801 1 00000000 3FFFFC8B 0 1 1 00000000
164D0803 1 00000000 BFFFFC8B 0 1 1 00000000
666D0400 1 00000000 C00003D9 0 1 1 00000000
668D0001 1 00000000 600001EC 0 1 1 00000000
66AD0211 1 00000000 FFFFE000 0 1 1 00000000
66CD041F 1 00000000 80000000 0 1 1 00000000
66ED001F 1 00000000 00000001 0 1 1 00000000
670D021F 1 00000000 FFFFFFFF 0 1 1 00000000
67210411 1 00000000 00C80000 0 1 1 00000000
E3400100 1 00000000 00000100 8 1 3 00000040
E3600101 1 00000000 00000101 4 1 3 00000040
E3800102 1 00000000 00000102 2 1 3 00000040
E3800103 1 00000000 00000103 1 1 3 00000040
E7A00200 1 00000000 00000200 C 1 3 00000080
E7A00202 1 00000000 00000202 3 1 3 00000080
EBC00304 1 00000000 00000304 F 1 3 000000C1
23FE0001 1 00000000 12345679 0 0 1 00000000
20200003 1 12345678 00000003 0 0 1 00000000
9401C001 1 00000000 00000003 0 0 1 00000000
94408001 1 00000000 00000003 0 0 1 00000000
00000000 0 00000000 00000003 0 0 2 00000000
00000000 0 00000000 00000003 0 0 2 00000000
00000000 0 00000000 00000003 0 0 2 00000000
94608000 1 00000000 00000094 0 0 1 00000000

// ==== verification/execTb.sv ====
`timescale 1ns/100ps

module execTb;

   localparam int numRows     = 41;
   localparam int numCols     = 8;
   localparam int resetCycles = 3;
   localparam int watchdogNs  = (numRows + 10) * 100;

   logic             gclk;
   logic             grst;
   execPkg::wordT    instr;
   logic             instrEn;
   execPkg::wordT    dataIn;
   execPkg::wordT    result;
   logic             resultEn;
   execPkg::byteSelT byteSel;
   execPkg::wordT    busAddr;
   logic             msrCarry;
   logic             msrIe;

   logic [31:0]   stim [0:numRows*numCols-1];
   execPkg::wordT busSeen [0:numRows-1];  // Bus address seen while each row executed

   execTop u_execTop (
      .gclk     (gclk),
      .grst     (grst),
      .instr    (instr),
      .instrEn  (instrEn),
      .dataIn   (dataIn),
      .result   (result),
      .resultEn (resultEn),
      .byteSel  (byteSel),
      .busAddr  (busAddr),
      .msrCarry (msrCarry),
      .msrIe    (msrIe)
   );

   initial gclk = 1'b0;
   always #50 gclk = ~gclk;

   task automatic reportFail(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                 input logic [31:0] actVal);
      reportFail($sformatf("Mismatch at %0t ns: %s expected %h got %h",
                           $time, name, expVal, actVal));
   endtask

   // Column k of row r in the data file
   function automatic logic [31:0] field(input int r, input int k);
      return stim[r*numCols + k];
   endfunction

   task automatic driveRow(input int r);
      instr   = field(r, 0);
      instrEn = 1'(field(r, 1));
      dataIn  = field(r, 2);
   endtask

   task automatic driveIdle();
      instr   = '0;
      instrEn = 1'b0;
      dataIn  = '0;
   endtask

   // Flag 2 marks an idle slot and flag 3 adds the bus address to a result check
   task automatic checkRow(input int r);
      logic [31:0] flag;
      logic [31:0] expResult;
      logic [3:0]  expSel;
      logic        expCarry;
      flag      = field(r, 6);
      expResult = field(r, 3);
      expSel    = 4'(field(r, 4));
      expCarry  = 1'(field(r, 5));
      if (flag != 0) begin
         if (flag == 2) begin
            assert (!resultEn)
            else reportFail($sformatf("resultEn high after idle row %0d", r));
         end else begin
            assert (resultEn)
            else reportFail($sformatf("resultEn low when row %0d should have a result", r));
         end
         assert (result == expResult)
         else reportMismatch("result", expResult, result);
         assert (byteSel == expSel)
         else reportMismatch("byteSel", {28'd0, expSel}, {28'd0, byteSel});
         assert (msrCarry == expCarry)
         else reportMismatch("msrCarry", {31'd0, expCarry}, {31'd0, msrCarry});
         if (flag == 3) begin
            assert (busSeen[r] == field(r, 7))
            else reportMismatch("busAddr", field(r, 7), busSeen[r]);
         end
      end
   endtask

   initial begin
      #(watchdogNs);
      reportFail("Timeout: the test did not finish all rows in time");
   end

   initial begin
      grst = 1'b1;
      driveIdle();
      $readmemh("verification/execInput.txt", stim);

      repeat (resetCycles) @(posedge gclk);
      #5 grst = 1'b0;

      for (int t = 0; t < numRows + 2; t++) begin
         @(posedge gclk);
         #5;
         if (t >= 2) begin
            checkRow(t - 2);  // Result of the row driven two edges ago
         end
         if ((t >= 1) && (t - 1 < numRows)) begin
            busSeen[t-1] = busAddr;
         end
         if (t < numRows) begin
            driveRow(t);
         end else begin
            driveIdle();
         end
      end

      assert (msrIe)
      else reportFail("msrIe stayed low after mts set the IE bit");

      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== src/execTop.sv ====
`timescale 1ns/100ps

module execTop (
   input  logic             gclk,
   input  logic             grst,
   input  execPkg::wordT    instr,
   input  logic             instrEn,
   input  execPkg::wordT    dataIn,
   output execPkg::wordT    result,
   output logic             resultEn,
   output execPkg::byteSelT byteSel,
   output execPkg::wordT    busAddr,
   output logic             msrCarry,
   output logic             msrIe
);

   execPkg::regAddrT  rdAddrA;
   execPkg::regAddrT  rdAddrB;
   execPkg::wordT     rdDataA;
   execPkg::wordT     rdDataB;
   execPkg::execCtrlT ctrl;
   execPkg::wordT     opA;
   execPkg::wordT     opB;
   logic              exEn;
   execPkg::wbT       wb;

   instrDecode u_instrDecode (
      .gclk    (gclk),
      .grst    (grst),
      .instr   (instr),
      .instrEn (instrEn),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .ctrl    (ctrl),
      .opA     (opA),
      .opB     (opB),
      .exEn    (exEn)
   );

   regFile u_regFile (
      .gclk    (gclk),
      .grst    (grst),
      .rdAddrA (rdAddrA),
      .rdAddrB (rdAddrB),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wb      (wb),
      .dataIn  (dataIn)
   );

   aluCore u_aluCore (
      .gclk     (gclk),
      .grst     (grst),
      .ctrl     (ctrl),
      .opA      (opA),
      .opB      (opB),
      .exEn     (exEn),
      .dataIn   (dataIn),
      .result   (result),
      .resultEn (resultEn),
      .byteSel  (byteSel),
      .busAddr  (busAddr),
      .msrCarry (msrCarry),
      .msrIe    (msrIe),
      .wb       (wb)
   );

endmodule

// ==== src/aluCore.sv ====
`timescale 1ns/100ps

module aluCore (
   input  logic              gclk,
   input  logic              grst,
   input  execPkg::execCtrlT ctrl,
   input  execPkg::wordT     opA,
   input  execPkg::wordT     opB,
   input  logic              exEn,
   input  execPkg::wordT     dataIn,
   output execPkg::wordT     result,
   output logic              resultEn,
   output execPkg::byteSelT  byteSel,
   output execPkg::wordT     busAddr,
   output logic              msrCarry,
   output logic              msrIe,
   output execPkg::wbT       wb
);

   execPkg::wordT    aVal;
   execPkg::wordT    bVal;
   logic             subOp;
   logic             addCin;
   logic             addCarry;
   logic             isCmp;
   logic             cmpBit;
   execPkg::wordT    addInA;
   execPkg::wordT    addSum;
   execPkg::wordT    addRes;
   execPkg::wordT    logicRes;
   execPkg::wordT    shiftRes;
   logic             shiftCarry;
   logic             isMts;
   execPkg::wordT    msrWord;
   execPkg::wordT    moveRes;
   execPkg::wordT    barrelRes;
   execPkg::wordT    loadAddr;
   execPkg::wordT    nextResult;
   execPkg::byteSelT nextSel;
   logic             msrBe;
   logic             msrBip;
   logic             nextC;
   logic             nextIe;
   logic             nextBe;
   logic             nextBip;
   logic             wbWrite;
   logic             wbLoad;
   execPkg::regAddrT wbRd;

   // Operand select
   always_comb begin
      case (ctrl.srcA)
         execPkg::srcReg:       aVal = opA;
         execPkg::srcFwdResult: aVal = result;
         execPkg::srcFwdLoad:   aVal = dataIn;
         default:               aVal = ctrl.pc;
      endcase
      case (ctrl.srcB)
         execPkg::srcReg:       bVal = opB;
         execPkg::srcFwdResult: bVal = result;
         execPkg::srcFwdLoad:   bVal = dataIn;
         default:               bVal = opB;  // Immediate already in opB
      endcase
   end

   // Reverse subtract, B + ~A + 1
   assign subOp  = |(ctrl.opc & (execPkg::opRsub ^ execPkg::opAdd));
   assign addInA = subOp ? ~aVal : aVal;
   assign addCin = ctrl.opc[1] ? msrCarry : subOp;  // Bit 1 selects carry-in
   assign {addCarry, addSum} = {1'b0, bVal} + {1'b0, addInA} + {32'd0, addCin};

   assign isCmp  = (ctrl.opc == execPkg::opCmp) && ctrl.imm16[0];
   assign cmpBit = ctrl.imm16[1] ? !addCarry : ($signed(aVal) > $signed(bVal));
   assign addRes = isCmp ? {cmpBit, addSum[30:0]} : addSum;

   always_comb begin
      case (ctrl.opc[1:0])
         2'd0:    logicRes = aVal | bVal;
         2'd1:    logicRes = aVal & bVal;
         2'd2:    logicRes = aVal ^ bVal;
         default: logicRes = aVal & ~bVal;  // andn
      endcase
   end

   // Single-bit shifts, bit 0 goes out to carry
   always_comb begin
      shiftCarry = aVal[0];
      case (ctrl.imm16[6:5])
         2'd0: shiftRes = {aVal[31], aVal[31:1]};
         2'd1: shiftRes = {msrCarry, aVal[31:1]};
         2'd2: shiftRes = {1'b0, aVal[31:1]};
         default: begin
            // sext16 or sext8, carry kept
            shiftRes   = ctrl.imm16[0] ? {{16{aVal[15]}}, aVal[15:0]}
                                       : {{24{aVal[7]}}, aVal[7:0]};
            shiftCarry = msrCarry;
         end
      endcase
   end

   assign isMts   = (ctrl.group == execPkg::grpMove) && ctrl.imm16[14];
   assign msrWord = {msrCarry, 27'd0, msrBip, msrCarry, msrIe, msrBe};
   // PC arrives as operand A for move-from-PC
   assign moveRes = (!ctrl.imm16[14] && ctrl.imm16[0]) ? msrWord : aVal;

   always_comb begin
      case (ctrl.imm16[10:9])
         2'd0:    barrelRes = aVal >> bVal[4:0];
         2'd1:    barrelRes = $unsigned($signed(aVal) >>> bVal[4:0]);
         2'd2:    barrelRes = aVal << bVal[4:0];
         default: barrelRes = '0;
      endcase
      if (!execPkg::hasBarrel) begin
         barrelRes = '0;
      end
   end

   assign loadAddr = aVal + bVal;
   assign busAddr  = {2'b00, loadAddr[31:2]};  // Word address

   // Byte lanes, MSB lane holds the lowest byte address
   always_comb begin
      nextSel = '0;
      if (ctrl.isLoad) begin
         case (ctrl.opc[1:0])
            2'd0: begin
               case (loadAddr[1:0])
                  2'd0:    nextSel = 4'h8;
                  2'd1:    nextSel = 4'h4;
                  2'd2:    nextSel = 4'h2;
                  default: nextSel = 4'h1;
               endcase
            end
            2'd1:    nextSel = loadAddr[1] ? 4'h3 : 4'hC;
            2'd2:    nextSel = 4'hF;
            default: nextSel = 4'h0;
         endcase
      end
   end

   always_comb begin
      case (ctrl.group)
         execPkg::grpAdd:    nextResult = addRes;
         execPkg::grpLogic:  nextResult = logicRes;
         execPkg::grpShift:  nextResult = shiftRes;
         execPkg::grpMove:   nextResult = moveRes;
         execPkg::grpLoad:   nextResult = loadAddr;
         execPkg::grpBarrel: nextResult = barrelRes;
         default:            nextResult = '0;
      endcase
   end

   // MSR update
   always_comb begin
      nextC   = msrCarry;
      nextIe  = msrIe;
      nextBe  = msrBe;
      nextBip = msrBip;
      case (ctrl.group)
         execPkg::grpAdd: begin
            if ({ctrl.opc[5:4], ctrl.opc[2]} == 3'b000) begin  // Not the keep forms
               nextC = addCarry;
            end
         end
         execPkg::grpShift: nextC = shiftCarry;
         execPkg::grpMove: begin
            if (isMts) begin
               nextC   = aVal[2];
               nextIe  = aVal[1];
               nextBe  = aVal[0];
               nextBip = aVal[3];
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         resultEn <= 1'b0;
         result   <= '0;
         byteSel  <= '0;
         msrCarry <= 1'b0;
         msrIe    <= 1'b0;
         msrBe    <= 1'b0;
         msrBip   <= 1'b0;
         wbWrite  <= 1'b0;
         wbLoad   <= 1'b0;
      end else begin
         resultEn <= exEn;
         if (exEn) begin
            result   <= nextResult;
            byteSel  <= nextSel;
            msrCarry <= nextC;
            msrIe    <= nextIe;
            msrBe    <= nextBe;
            msrBip   <= nextBip;
            wbWrite  <= ctrl.writeEn;
            wbLoad   <= ctrl.isLoad;
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (exEn) begin
         wbRd <= ctrl.rd;
      end
   end

   always_comb begin
      wb.wbEn     = resultEn && wbWrite;  // One pulse per executed instruction
      wb.wbLoad   = wbLoad;
      wb.wbRd     = wbRd;
      wb.wbResult = result;
   end

   a_groupValid : assert property (@(posedge gclk) disable iff (grst)
      exEn |-> (ctrl.group inside {execPkg::grpAdd, execPkg::grpLogic,
                                   execPkg::grpShift, execPkg::grpMove,
                                   execPkg::grpLoad, execPkg::grpBarrel}));

   // Decode must never forward r0
   a_noFwdR0 : assert property (@(posedge gclk) disable iff (grst)
      (exEn && ((ctrl.srcA == execPkg::srcFwdResult) ||
                (ctrl.srcA == execPkg::srcFwdLoad))) |-> (ctrl.ra != '0));

endmodule

// ==== src/instrDecode.sv ====
`timescale 1ns/100ps

module instrDecode (
   input  logic              gclk,
   input  logic              grst,
   input  execPkg::wordT     instr,
   input  logic              instrEn,
   input  execPkg::wordT     rdDataA,
   input  execPkg::wordT     rdDataB,
   output execPkg::regAddrT  rdAddrA,
   output execPkg::regAddrT  rdAddrB,
   output execPkg::execCtrlT ctrl,
   output execPkg::wordT     opA,
   output execPkg::wordT     opB,
   output logic              exEn
);

   execPkg::opcodeT   opc;
   execPkg::opcodeT   base;
   execPkg::regAddrT  rd;
   execPkg::regAddrT  ra;
   execPkg::regAddrT  rb;
   logic [15:0]       imm16;
   logic              useImm;
   execPkg::wordT     immExt;
   execPkg::wordT     pcCnt;
   execPkg::execCtrlT nextCtrl;

   // MicroBlaze type A/B field split
   assign opc    = instr[31:26];
   assign rd     = instr[25:21];
   assign ra     = instr[20:16];
   assign rb     = instr[15:11];
   assign imm16  = instr[15:0];
   assign useImm = opc[execPkg::immBit];
   assign immExt = {{16{imm16[15]}}, imm16};

   assign rdAddrA = ra;
   assign rdAddrB = rb;

   // The instruction now in execute is the previous accepted one
   function automatic execPkg::srcSelT fwdSel(input execPkg::regAddrT addr);
      if (exEn && ctrl.writeEn && (addr != '0) && (addr == ctrl.rd)) begin
         return ctrl.isLoad ? execPkg::srcFwdLoad : execPkg::srcFwdResult;
      end
      return execPkg::srcReg;  // Regfile or its bypass covers older writers
   endfunction

   always_comb begin
      base = opc;
      base[execPkg::immBit] = 1'b0;  // Fold immediate forms onto register forms

      nextCtrl         = '0;
      nextCtrl.opc     = opc;
      nextCtrl.imm16   = imm16;
      nextCtrl.rd      = rd;
      nextCtrl.ra      = ra;
      nextCtrl.pc      = pcCnt;
      nextCtrl.group   = execPkg::grpAdd;
      nextCtrl.writeEn = 1'b1;

      case (base)
         execPkg::opOr, execPkg::opAnd, execPkg::opXor, execPkg::opAndn:
            nextCtrl.group = execPkg::grpLogic;
         execPkg::opShift:
            nextCtrl.group = execPkg::grpShift;
         execPkg::opBarrel:
            nextCtrl.group = execPkg::grpBarrel;
         execPkg::opMsr: begin
            nextCtrl.group   = execPkg::grpMove;
            nextCtrl.writeEn = !imm16[14];  // mts only touches the MSR
         end
         execPkg::opLoadByte, execPkg::opLoadHalf, execPkg::opLoadWord: begin
            nextCtrl.group  = execPkg::grpLoad;
            nextCtrl.isLoad = 1'b1;
         end
         default: begin
            // Add family is 0x00..0x07, anything else is dropped
            if (base[5:3] != execPkg::opAdd[5:3]) begin
               nextCtrl.writeEn = 1'b0;
            end
         end
      endcase

      // Move-from-PC takes the PC as operand A
      if ((nextCtrl.group == execPkg::grpMove) && !imm16[14] && !imm16[0]) begin
         nextCtrl.srcA = execPkg::srcPcImm;
      end else begin
         nextCtrl.srcA = fwdSel(ra);
      end
      nextCtrl.srcB = useImm ? execPkg::srcPcImm : fwdSel(rb);
   end

   always_ff @(posedge gclk) begin
      if (grst) begin
         exEn  <= 1'b0;
         ctrl  <= '0;
         pcCnt <= '0;
      end else begin
         exEn <= instrEn;
         if (instrEn) begin
            ctrl  <= nextCtrl;
            pcCnt <= pcCnt + 32'd4;  // No branches, just count words
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (instrEn) begin
         opA <= rdDataA;
         opB <= useImm ? immExt : rdDataB;
      end
   end

   a_noExAfterRst : assert property (@(posedge gclk) grst |=> !exEn);

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/100ps

module regFile (
   input  logic            gclk,
   input  logic            grst,
   input  execPkg::regAddrT rdAddrA,
   input  execPkg::regAddrT rdAddrB,
   output execPkg::wordT   rdDataA,
   output execPkg::wordT   rdDataB,
   input  execPkg::wbT     wb,
   input  execPkg::wordT   dataIn
);

   execPkg::wordT regs [31:1];  // r0 is not stored
   execPkg::wordT wrData;
   logic          wrEn;

   // Load data arrives on the bus, everything else from the result register
   assign wrData = wb.wbLoad ? dataIn : wb.wbResult;
   assign wrEn   = wb.wbEn && (wb.wbRd != '0);

   always_ff @(posedge gclk) begin
      if (wrEn) begin
         regs[wb.wbRd] <= wrData;
      end
   end

   // Write-through so the read sees a write landing this edge
   function automatic execPkg::wordT readPort(input execPkg::regAddrT addr);
      if (addr == '0) begin
         return '0;
      end
      if (wrEn && (addr == wb.wbRd)) begin
         return wrData;
      end
      return regs[addr];
   endfunction

   always_comb begin
      rdDataA = readPort(rdAddrA);
      rdDataB = readPort(rdAddrB);
   end

   // r0 stays zero after a write aimed at it
   a_r0Zero : assert property (@(posedge gclk) disable iff (grst)
      (wb.wbEn && (wb.wbRd == '0)) |=> ((rdAddrA != '0) || (rdDataA == '0)));

endmodule

// ==== src/execPkg.sv ====
package execPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;
   typedef logic [5:0]  opcodeT;
   typedef logic [3:0]  byteSelT;  // Lane 3 (MSB) first

   // Operand source, last value is PC for A and immediate for B
   typedef enum logic [1:0] {
      srcReg,
      srcFwdResult,
      srcFwdLoad,
      srcPcImm
   } srcSelT;

   // Result source of the execute stage
   typedef enum logic [2:0] {
      grpAdd,
      grpLogic,
      grpShift,
      grpMove,
      grpLoad,
      grpBarrel
   } aluGroupT;

   localparam bit hasBarrel = 1'b1;

   // Primary opcodes, register form
   localparam opcodeT opAdd      = 6'h00;
   localparam opcodeT opRsub     = 6'h01;
   localparam opcodeT opCmp      = 6'h05;  // rsubk, imm bit 0 set
   localparam opcodeT opBarrel   = 6'h11;
   localparam opcodeT opOr       = 6'h20;
   localparam opcodeT opAnd      = 6'h21;
   localparam opcodeT opXor      = 6'h22;
   localparam opcodeT opAndn     = 6'h23;
   localparam opcodeT opShift    = 6'h24;
   localparam opcodeT opMsr      = 6'h25;
   localparam opcodeT opLoadByte = 6'h30;
   localparam opcodeT opLoadHalf = 6'h31;
   localparam opcodeT opLoadWord = 6'h32;
   localparam int     immBit     = 3;      // Set for the immediate form

   typedef struct packed {
      opcodeT      opc;
      logic [15:0] imm16;
      regAddrT     rd;
      regAddrT     ra;
      srcSelT      srcA;
      srcSelT      srcB;
      aluGroupT    group;
      logic        writeEn;
      logic        isLoad;
      wordT        pc;
   } execCtrlT;

   typedef struct packed {
      logic    wbEn;
      logic    wbLoad;
      regAddrT wbRd;
      wordT    wbResult;
   } wbT;

endpackage
